// ==== design/prf_pkg.sv ====
`default_nettype none

package prf_pkg;

    // sizing of the physical register file.
    localparam int unsigned phys_regs = 64;
    localparam int unsigned xlen = 32;
    localparam int unsigned tag_bits = $clog2(phys_regs);

    // port counts on the issue and writeback side.
    localparam int unsigned issue_width = 2;
    localparam int unsigned wb_ports = 2;
    localparam int unsigned alloc_ports = 2;

    // two sources per issue slot.
    localparam int unsigned read_ports = issue_width * 2;

    // physical register number and data word.
    typedef logic [tag_bits-1:0] phys_tag_t;
    typedef logic [xlen-1:0] word_t;

    // one result coming back from an execution unit.
    typedef struct packed {
        logic      valid;
        phys_tag_t tag;
        word_t     data;
    } wb_port_t;

    // a destination register just handed out by rename.
    typedef struct packed {
        logic      valid;
        phys_tag_t tag;
    } alloc_t;

    // source tags of one instruction picked for issue.
    typedef struct packed {
        logic      valid;
        phys_tag_t src1;
        phys_tag_t src2;
    } issue_req_t;

    // operands returned to an issue slot one cycle later.
    typedef struct packed {
        logic  valid;
        logic  ready1;
        logic  ready2;
        word_t data1;
        word_t data2;
    } operand_resp_t;

endpackage

`default_nettype wire

// ==== design/phys_reg_file.sv ====
`default_nettype none

module phys_reg_file (
    input  logic               clock,
    input  logic               reset,
    input  prf_pkg::wb_port_t  wb [prf_pkg::wb_ports],
    input  prf_pkg::phys_tag_t read_tag [prf_pkg::read_ports],
    output prf_pkg::word_t     read_data [prf_pkg::read_ports]
);

    // one word per physical register.
    prf_pkg::word_t regs [prf_pkg::phys_regs];

    // writeback ports that really write this cycle.
    logic [prf_pkg::wb_ports-1:0] wb_live;

    // a write to register 0 is dropped.
    always_comb begin
        for (int w = 0; w < prf_pkg::wb_ports; w++) begin
            wb_live[w] = wb[w].valid && (wb[w].tag != '0);
        end
    end

    // storage update.
    always_ff @(posedge clock) begin
        if (reset) begin
            // all registers come out of reset as zero.
            for (int i = 0; i < prf_pkg::phys_regs; i++) begin
                regs[i] <= '0;
            end
        end else begin
            // walked in port order, so on a tag clash the last port lands.
            for (int w = 0; w < prf_pkg::wb_ports; w++) begin
                if (wb_live[w]) begin
                    regs[wb[w].tag] <= wb[w].data;
                end
            end
        end
    end

    // read side.
    always_comb begin
        for (int r = 0; r < prf_pkg::read_ports; r++) begin
            // stored value first.
            read_data[r] = regs[read_tag[r]];
            // then same-cycle results override it, higher port last.
            for (int w = 0; w < prf_pkg::wb_ports; w++) begin
                if (wb_live[w] && (wb[w].tag == read_tag[r])) begin
                    read_data[r] = wb[w].data;
                end
            end
        end
    end

    // register 0 holds zero in every cycle out of reset.
    reg0_zero: assert property (
        @(posedge clock) disable iff (reset)
        regs[0] == '0
    ) else $error("phys_reg_file: register 0 lost its zero value");

endmodule

`default_nettype wire

// ==== design/ready_table.sv ====
`default_nettype none

module ready_table (
    input  logic                              clock,
    input  logic                              reset,
    input  prf_pkg::wb_port_t                 wb [prf_pkg::wb_ports],
    input  prf_pkg::alloc_t                   alloc [prf_pkg::alloc_ports],
    input  prf_pkg::phys_tag_t                read_tag [prf_pkg::read_ports],
    output logic [prf_pkg::read_ports-1:0]    read_ready
);

    // one ready bit per physical register.
    logic [prf_pkg::phys_regs-1:0] ready_q;

    // writebacks that set a bit this cycle.
    logic [prf_pkg::wb_ports-1:0] wb_live;

    // register 0 is never tracked.
    always_comb begin
        for (int w = 0; w < prf_pkg::wb_ports; w++) begin
            wb_live[w] = wb[w].valid && (wb[w].tag != '0);
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            // nothing is in flight after reset.
            ready_q <= '1;
        end else begin
            // a fresh destination waits for its result.
            for (int a = 0; a < prf_pkg::alloc_ports; a++) begin
                if (alloc[a].valid) begin
                    ready_q[alloc[a].tag] <= 1'b0;
                end
            end
            // a result makes its register ready.
            for (int w = 0; w < prf_pkg::wb_ports; w++) begin
                if (wb_live[w]) begin
                    ready_q[wb[w].tag] <= 1'b1;
                end
            end
            // zero register is always ready.
            ready_q[0] <= 1'b1;
        end
    end

    // lookup with bypass from this cycle's results.
    always_comb begin
        for (int r = 0; r < prf_pkg::read_ports; r++) begin
            read_ready[r] = ready_q[read_tag[r]];
            for (int w = 0; w < prf_pkg::wb_ports; w++) begin
                if (wb_live[w] && (wb[w].tag == read_tag[r])) begin
                    read_ready[r] = 1'b1;
                end
            end
        end
    end

    for (genvar a = 0; a < prf_pkg::alloc_ports; a++) begin : g_alloc_chk
        // rename never hands out register 0.
        alloc_nonzero: assert property (
            @(posedge clock) disable iff (reset)
            alloc[a].valid |-> (alloc[a].tag != '0)
        ) else $error("ready_table: allocation of tag 0");

        for (genvar w = 0; w < prf_pkg::wb_ports; w++) begin : g_wb_chk
            // a register cannot be handed out while its old result is still returning.
            alloc_wb_clash: assert property (
                @(posedge clock) disable iff (reset)
                !(alloc[a].valid && wb_live[w] && (alloc[a].tag == wb[w].tag))
            ) else $error("ready_table: allocation and writeback of one tag");
        end
    end

endmodule

`default_nettype wire

// ==== design/operand_fetch.sv ====
`default_nettype none

module operand_fetch (
    input  logic                              clock,
    input  logic                              reset,
    input  prf_pkg::issue_req_t               issue [prf_pkg::issue_width],
    output prf_pkg::phys_tag_t                read_tag [prf_pkg::read_ports],
    input  prf_pkg::word_t                    read_data [prf_pkg::read_ports],
    input  logic [prf_pkg::read_ports-1:0]    read_ready,
    output prf_pkg::operand_resp_t            resp [prf_pkg::issue_width]
);

    // response register, one entry per slot.
    prf_pkg::operand_resp_t resp_q [prf_pkg::issue_width];

    // slot-major read port layout.
    // port 2s carries src1 of slot s and port 2s+1 carries src2.
    always_comb begin
        for (int s = 0; s < prf_pkg::issue_width; s++) begin
            read_tag[2*s] = issue[s].src1;
            read_tag[2*s+1] = issue[s].src2;
        end
    end

    always_ff @(posedge clock) begin
        for (int s = 0; s < prf_pkg::issue_width; s++) begin
            // operand payload is sampled every cycle.
            resp_q[s].ready1 <= read_ready[2*s];
            resp_q[s].ready2 <= read_ready[2*s+1];
            resp_q[s].data1 <= read_data[2*s];
            resp_q[s].data2 <= read_data[2*s+1];
            // only the valid flag is cleared by reset.
            if (reset) begin
                resp_q[s].valid <= 1'b0;
            end else begin
                resp_q[s].valid <= issue[s].valid;
            end
        end
    end

    // drive the slot outputs straight from the register.
    always_comb begin
        for (int s = 0; s < prf_pkg::issue_width; s++) begin
            resp[s] = resp_q[s];
        end
    end

    for (genvar s = 0; s < prf_pkg::issue_width; s++) begin : g_resp_chk
        // a response always answers an issue from the cycle before.
        resp_has_issue: assert property (
            @(posedge clock) disable iff (reset)
            resp_q[s].valid |-> $past(issue[s].valid)
        ) else $error("operand_fetch: response without an issue one cycle earlier");

        // operands read during a writeback to register 0 still come back zero.
        zero_src1: assert property (
            @(posedge clock) disable iff (reset)
            (issue[s].valid && (issue[s].src1 == '0)) |=>
                (resp_q[s].data1 == '0) && resp_q[s].ready1
        ) else $error("operand_fetch: register 0 read back nonzero or not ready");
    end

endmodule

`default_nettype wire

// ==== design/prf_subsystem.sv ====
`default_nettype none

module prf_subsystem (
    input  logic                   clock,
    input  logic                   reset,
    input  prf_pkg::wb_port_t      wb [prf_pkg::wb_ports],
    input  prf_pkg::alloc_t        alloc [prf_pkg::alloc_ports],
    input  prf_pkg::issue_req_t    issue [prf_pkg::issue_width],
    output prf_pkg::operand_resp_t resp [prf_pkg::issue_width]
);

    // read addresses from the issue stage, slot-major.
    prf_pkg::phys_tag_t read_tag [prf_pkg::read_ports];

    // operand values, already bypassed.
    prf_pkg::word_t read_data [prf_pkg::read_ports];

    // operand readiness, already bypassed.
    logic [prf_pkg::read_ports-1:0] read_ready;

    // issue side, the only registered stage.
    operand_fetch operand_fetch_i (
        .clock      (clock),
        .reset      (reset),
        .issue      (issue),
        .read_tag   (read_tag),
        .read_data  (read_data),
        .read_ready (read_ready),
        .resp       (resp)
    );

    // data storage, written by the execution units.
    phys_reg_file phys_reg_file_i (
        .clock     (clock),
        .reset     (reset),
        .wb        (wb),
        .read_tag  (read_tag),
        .read_data (read_data)
    );

    // readiness, cleared by rename and set by writeback.
    ready_table ready_table_i (
        .clock      (clock),
        .reset      (reset),
        .wb         (wb),
        .alloc      (alloc),
        .read_tag   (read_tag),
        .read_ready (read_ready)
    );

endmodule

`default_nettype wire

// ==== verification/prf_tb.sv ====
`default_nettype none

module prf_tb;

    timeunit 1ns;
    timeprecision 1ps;

    logic clock = 1'b0;
    logic reset;

    // DUT ports.
    prf_pkg::wb_port_t      wb [prf_pkg::wb_ports];
    prf_pkg::alloc_t        alloc [prf_pkg::alloc_ports];
    prf_pkg::issue_req_t    issue [prf_pkg::issue_width];
    prf_pkg::operand_resp_t resp [prf_pkg::issue_width];

    // one entry per stimulus line, ports flattened line-major.
    string                  names [$];
    prf_pkg::wb_port_t      wb_q [$];
    prf_pkg::alloc_t        alloc_q [$];
    prf_pkg::issue_req_t    issue_q [$];
    prf_pkg::operand_resp_t expect_q [$];

    // run length guard.
    int cycle_count = 0;
    int cycle_limit;

    // 40 ns period.
    always #20 clock = ~clock;

    prf_subsystem prf_subsystem_i (
        .clock (clock),
        .reset (reset),
        .wb    (wb),
        .alloc (alloc),
        .issue (issue),
        .resp  (resp)
    );

    task automatic stop_with_failure();
        $display("Simulation finished: FAIL");
        $fatal(1, "run aborted");
    endtask

    // compares one slot; an idle slot only has its valid flag checked.
    task automatic check_resp(input string test_name, input int slot,
                              input prf_pkg::operand_resp_t expected,
                              input prf_pkg::operand_resp_t actual);
        logic mismatch;
        if (expected.valid) begin
            mismatch = (actual !== expected);
        end else begin
            mismatch = (actual.valid !== 1'b0);
        end
        if (mismatch) begin
            $display("Error %s slot %0d: expected valid=%b ready=%b%b data=%h %h",
                     test_name, slot, expected.valid, expected.ready1, expected.ready2,
                     expected.data1, expected.data2);
            $display("      actual valid=%b ready=%b%b data=%h %h",
                     actual.valid, actual.ready1, actual.ready2, actual.data1, actual.data2);
            stop_with_failure();
        end
    endtask

    // reads the whole data file into the queues.
    task automatic load_stimulus();
        int          fd;
        int          n;
        string       line;
        string       name;
        logic [31:0] f [26];
        fd = $fopen("verification/prf_stim.txt", "r");
        if (fd == 0) begin
            $display("Could not open verification/prf_stim.txt.");
            stop_with_failure();
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            // skip blank lines and comments.
            if (n == 0 || line.len() == 0 || line[0] == "#" || line[0] == "\n") begin
                continue;
            end
            n = $sscanf(line,
                "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                name, f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
                f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19],
                f[20], f[21], f[22], f[23], f[24], f[25]);
            if (n != 27) begin
                $display("Stimulus line has %0d fields instead of 27: %s", n, line);
                stop_with_failure();
            end
            names.push_back(name);
            // writeback fields start at column 0, three per port.
            for (int p = 0; p < 2; p++) begin
                wb_q.push_back(prf_pkg::wb_port_t'{f[3*p][0],
                    f[3*p+1][prf_pkg::tag_bits-1:0], f[3*p+2]});
            end
            // allocation fields start at column 6.
            for (int p = 0; p < 2; p++) begin
                alloc_q.push_back(prf_pkg::alloc_t'{f[6+2*p][0],
                    f[7+2*p][prf_pkg::tag_bits-1:0]});
            end
            // issue fields start at column 10.
            for (int p = 0; p < 2; p++) begin
                issue_q.push_back(prf_pkg::issue_req_t'{f[10+3*p][0],
                    f[11+3*p][prf_pkg::tag_bits-1:0], f[12+3*p][prf_pkg::tag_bits-1:0]});
            end
            // expected responses start at column 16, five per slot.
            for (int p = 0; p < 2; p++) begin
                expect_q.push_back(prf_pkg::operand_resp_t'{f[16+5*p][0], f[17+5*p][0],
                    f[18+5*p][0], f[19+5*p], f[20+5*p]});
            end
        end
        $fclose(fd);
    endtask

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles.", cycle_limit);
            stop_with_failure();
        end
    end

    initial begin
        // all inputs idle, reset asserted.
        reset <= 1'b1;
        for (int p = 0; p < prf_pkg::wb_ports; p++) begin
            wb[p] <= '0;
        end
        for (int p = 0; p < prf_pkg::alloc_ports; p++) begin
            alloc[p] <= '0;
        end
        for (int s = 0; s < prf_pkg::issue_width; s++) begin
            issue[s] <= '0;
        end
        load_stimulus();
        cycle_limit = names.size() + 10 + 20;
        repeat (10) @(posedge clock);
        reset <= 1'b0;
        // one line per cycle; the first goes out with the reset release.
        for (int i = 0; i < names.size(); i++) begin
            for (int p = 0; p < prf_pkg::wb_ports; p++) begin
                wb[p] <= wb_q[i*prf_pkg::wb_ports + p];
            end
            for (int p = 0; p < prf_pkg::alloc_ports; p++) begin
                alloc[p] <= alloc_q[i*prf_pkg::alloc_ports + p];
            end
            for (int s = 0; s < prf_pkg::issue_width; s++) begin
                issue[s] <= issue_q[i*prf_pkg::issue_width + s];
            end
            // resp is settled mid-cycle and answers the line before.
            @(negedge clock);
            for (int s = 0; s < prf_pkg::issue_width; s++) begin
                check_resp(names[i], s, expect_q[i*prf_pkg::issue_width + s], resp[s]);
            end
            @(posedge clock);
        end
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
design/prf_pkg.sv
design/phys_reg_file.sv
design/ready_table.sv
design/operand_fetch.sv
design/prf_subsystem.sv
verification/prf_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -f sim.log
verilator --binary --assert --timescale 1ns/1ps --top-module prf_tb \
    -f sources.f --Mdir obj_dir -o prf_sim

# the simulator exit status is not used; the log decides the result.
./obj_dir/prf_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
    echo "run.sh: simulation failed"
    exit 1
fi
if ! grep -q "Simulation finished: PASS" sim.log; then
    echo "run.sh: simulation ended without a result"
    exit 1
fi
echo "run.sh: simulation passed"

// ==== verification/prf_stim.txt ====
# name | wb0 v tag data | wb1 v tag data | alloc0 v tag | alloc1 v tag | issue0 v s1 s2 | issue1 v s1 s2
# then resp0 and resp1 expected as v r1 r2 d1 d2, answering the issue of the line before (hex)
# reset values
rst_idle 0 00 0 0 00 0 0 00 0 00 0 00 00 0 00 00 0 0 0 0 0 0 0 0 0 0
rst_read 0 00 0 0 00 0 0 00 0 00 1 05 3f 1 00 20 0 0 0 0 0 0 0 0 0 0
rst_chk 0 00 0 0 00 0 0 00 0 00 0 00 00 0 00 00 1 1 1 0 0 1 1 1 0 0
idle_gap 0 00 0 0 00 0 0 00 0 00 0 00 00 0 00 00 0 0 0 0 0 0 0 0 0 0
# writeback and read back, register 0 ignores writes
wb_write 1 05 1234abcd 1 3f 0badf00d 0 00 0 00 0 00 00 0 00 00 0 0 0 0 0 0 0 0 0 0
wb_read 0 00 0 0 00 0 0 00 0 00 1 05 3f 1 3f 05 0 0 0 0 0 0 0 0 0 0
wb_chk 1 00 ffffffff 0 00 0 0 00 0 00 1 00 00 0 00 00 1 1 1 1234abcd 0badf00d 1 1 1 0badf00d 1234abcd
zero_wb 0 00 0 0 00 0 0 00 0 00 0 00 00 1 00 05 1 1 1 0 0 0 0 0 0 0
# allocation clears ready, then same-cycle bypass
zero_chk 0 00 0 0 00 0 1 0a 1 0b 0 00 00 0 00 00 0 0 0 0 0 1 1 1 0 1234abcd
alloc_read 0 00 0 0 00 0 0 00 0 00 1 0a 0b 0 00 00 0 0 0 0 0 0 0 0 0 0
alloc_chk 1 0a 11111111 0 00 0 0 00 0 00 1 0a 0b 1 0a 0a 1 0 0 0 0 0 0 0 0 0
byp_chk 1 0b 22222222 1 0b 33333333 0 00 0 00 1 0b 0a 0 00 00 1 1 0 11111111 0 1 1 1 11111111 11111111
clash_byp 0 00 0 0 00 0 0 00 0 00 0 00 00 1 0b 0b 1 1 1 33333333 11111111 0 0 0 0 0
# reallocation keeps old data until the new result arrives
clash_mem 0 00 0 0 00 0 1 05 1 3f 1 05 3f 0 00 00 0 0 0 0 0 1 1 1 33333333 33333333
realloc 0 00 0 0 00 0 0 00 0 00 1 05 3f 1 3f 05 1 1 1 1234abcd 0badf00d 0 0 0 0 0
realloc_chk 0 00 0 1 05 cafe0001 0 00 0 00 0 00 00 0 00 00 1 0 0 1234abcd 0badf00d 1 0 0 0badf00d 1234abcd
rewrite 0 00 0 0 00 0 0 00 0 00 1 05 3f 0 00 00 0 0 0 0 0 0 0 0 0 0
rewrite_chk 1 3f 5a5a5a5a 0 00 0 0 00 0 00 0 00 00 0 00 00 1 1 0 cafe0001 0badf00d 0 0 0 0 0
# back-to-back issues
b2b_a 0 00 0 0 00 0 0 00 0 00 1 05 0a 1 0b 3f 0 0 0 0 0 0 0 0 0 0
b2b_b 1 20 77777777 0 00 0 0 00 0 00 1 3f 00 1 20 05 1 1 1 cafe0001 11111111 1 1 1 33333333 5a5a5a5a
b2b_c 0 00 0 0 00 0 0 00 0 00 1 20 0b 1 00 3f 1 1 1 5a5a5a5a 0 1 1 1 77777777 cafe0001
b2b_d 0 00 0 0 00 0 0 00 0 00 1 0a 0a 0 00 00 1 1 1 77777777 33333333 1 1 1 0 5a5a5a5a
b2b_e 0 00 0 0 00 0 0 00 0 00 0 00 00 0 00 00 1 1 1 11111111 11111111 0 0 0 0 0
drain 0 00 0 0 00 0 0 00 0 00 0 00 00 0 00 00 0 0 0 0 0 0 0 0 0 0
